//--- id_pkg.sv
package id_pkg;

  // Major opcode, inst[31:26]
  localparam logic [5:0] OP_GRP0   = 6'h00;
  localparam logic [5:0] OP_LU12I  = 6'h05;
  localparam logic [5:0] OP_PCADDU = 6'h07;
  localparam logic [5:0] OP_MEM    = 6'h0a;
  localparam logic [5:0] OP_JIRL   = 6'h13;
  localparam logic [5:0] OP_B      = 6'h14;
  localparam logic [5:0] OP_BL     = 6'h15;
  localparam logic [5:0] OP_BEQ    = 6'h16;
  localparam logic [5:0] OP_BNE    = 6'h17;
  localparam logic [5:0] OP_BLT    = 6'h18;
  localparam logic [5:0] OP_BGE    = 6'h19;
  localparam logic [5:0] OP_BLTU   = 6'h1a;
  localparam logic [5:0] OP_BGEU   = 6'h1b;

  // Minor opcode, inst[25:22]
  localparam logic [3:0] MN_3R    = 4'h0;
  localparam logic [3:0] MN_SHIFT = 4'h1;
  localparam logic [3:0] MN_SLTI  = 4'h8;
  localparam logic [3:0] MN_SLTUI = 4'h9;
  localparam logic [3:0] MN_ADDI  = 4'ha;
  localparam logic [3:0] MN_ANDI  = 4'hd;
  localparam logic [3:0] MN_ORI   = 4'he;
  localparam logic [3:0] MN_XORI  = 4'hf;
  localparam logic [3:0] MN_LD_B  = 4'h0;
  localparam logic [3:0] MN_LD_H  = 4'h1;
  localparam logic [3:0] MN_LD_W  = 4'h2;
  localparam logic [3:0] MN_ST_B  = 4'h4;
  localparam logic [3:0] MN_ST_H  = 4'h5;
  localparam logic [3:0] MN_ST_W  = 4'h6;
  localparam logic [3:0] MN_LD_BU = 4'h8;
  localparam logic [3:0] MN_LD_HU = 4'h9;

  // inst[21:20]
  localparam logic [1:0] F2_SHIFT = 2'h0;
  localparam logic [1:0] F2_ALU   = 2'h1;
  localparam logic [1:0] F2_TRAP  = 2'h2;

  // Function field, inst[19:15]
  localparam logic [4:0] F_ADD     = 5'h00;
  localparam logic [4:0] F_SUB     = 5'h02;
  localparam logic [4:0] F_SLT     = 5'h04;
  localparam logic [4:0] F_SLTU    = 5'h05;
  localparam logic [4:0] F_NOR     = 5'h08;
  localparam logic [4:0] F_AND     = 5'h09;
  localparam logic [4:0] F_OR      = 5'h0a;
  localparam logic [4:0] F_XOR     = 5'h0b;
  localparam logic [4:0] F_SLL     = 5'h0e;
  localparam logic [4:0] F_SRL     = 5'h0f;
  localparam logic [4:0] F_SRA     = 5'h10;
  localparam logic [4:0] F_SLLI    = 5'h01;
  localparam logic [4:0] F_SRLI    = 5'h09;
  localparam logic [4:0] F_SRAI    = 5'h11;
  localparam logic [4:0] F_BREAK   = 5'h14;
  localparam logic [4:0] F_SYSCALL = 5'h16;

  // One-hot ALU operation bits
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

  typedef struct packed {
    logic [5:0] op6;
    logic [3:0] op4;
    logic [1:0] op2;
    logic [4:0] op5;
    logic [4:0] rk, rj, rd;
  } fmt_3r_t;

  typedef struct packed {
    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [11:0] i12;
    logic [4:0]  rj, rd;
  } fmt_2ri12_t;

  typedef struct packed {
    logic [5:0]  op6;
    logic        op1;
    logic [19:0] i20;
    logic [4:0]  rd;
  } fmt_1ri20_t;

  typedef struct packed {
    logic [5:0]  op6;
    logic [15:0] i16;
    logic [4:0]  rj, rd;
  } fmt_2ri16_t;

  // Offset is split, high bits sit in the low field
  typedef struct packed {
    logic [5:0]  op6;
    logic [15:0] offs_lo;
    logic [9:0]  offs_hi;
  } fmt_i26_t;

  typedef union packed {
    fmt_3r_t    r3;
    fmt_2ri12_t ri12;
    fmt_1ri20_t ri20;
    fmt_2ri16_t ri16;
    fmt_i26_t   i26;
  } inst_word_u;

  typedef logic [11:0] alu_op_t;

  typedef struct packed { logic w, b, bu, h, hu; } ld_ctrl_t;
  typedef struct packed { logic w, h, b; } st_ctrl_t;
  typedef struct packed { logic sys, brk, ine; } exc_t;

  typedef enum logic [3:0] {
    BR_NONE, BR_B, BR_BL, BR_JIRL, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_kind_t;

  typedef struct packed {
    alu_op_t    alu_op;
    ld_ctrl_t   ld_ctrl;
    st_ctrl_t   st_ctrl;
    br_kind_t   br_kind;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       src_reg_is_rd;
    logic       rf_we;
    logic [4:0] dest;
    exc_t       exc;
  } dec_ctrl_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rj, rd, rk;
    dec_ctrl_t   ctrl;
    logic [31:0] imm;
    logic [31:0] br_offs;
  } id_s1_t;

  typedef struct packed {
    alu_op_t     alu_op;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    logic [31:0] st_data;
    ld_ctrl_t    ld_ctrl;
    st_ctrl_t    st_ctrl;
    logic        mem_en;
    logic        rf_we;
    logic [4:0]  dest;
    logic [31:0] pc;
    exc_t        exc;
  } id_ex_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } br_t;

endpackage

//--- id_inst_decoder.sv
`timescale 1ns/1ps

module id_inst_decoder (
  input  id_pkg::inst_word_u inst,
  output id_pkg::dec_ctrl_t  ctrl
);
  import id_pkg::*;

  logic known;

  always_comb begin
    ctrl       = '0;
    ctrl.dest  = inst.r3.rd;
    ctrl.rf_we = 1'b1;
    known      = 1'b1;
    case (inst.r3.op6)
      OP_GRP0: begin
        if (inst.r3.op4 == MN_3R && inst.r3.op2 == F2_ALU) begin
          case (inst.r3.op5)
            F_ADD:   ctrl.alu_op[ALU_ADD]  = 1'b1;
            F_SUB:   ctrl.alu_op[ALU_SUB]  = 1'b1;
            F_SLT:   ctrl.alu_op[ALU_SLT]  = 1'b1;
            F_SLTU:  ctrl.alu_op[ALU_SLTU] = 1'b1;
            F_NOR:   ctrl.alu_op[ALU_NOR]  = 1'b1;
            F_AND:   ctrl.alu_op[ALU_AND]  = 1'b1;
            F_OR:    ctrl.alu_op[ALU_OR]   = 1'b1;
            F_XOR:   ctrl.alu_op[ALU_XOR]  = 1'b1;
            F_SLL:   ctrl.alu_op[ALU_SLL]  = 1'b1;
            F_SRL:   ctrl.alu_op[ALU_SRL]  = 1'b1;
            F_SRA:   ctrl.alu_op[ALU_SRA]  = 1'b1;
            default: known = 1'b0;
          endcase
        end else if (inst.r3.op4 == MN_SHIFT && inst.r3.op2 == F2_SHIFT) begin
          ctrl.src2_is_imm = 1'b1;
          case (inst.r3.op5)
            F_SLLI:  ctrl.alu_op[ALU_SLL] = 1'b1;
            F_SRLI:  ctrl.alu_op[ALU_SRL] = 1'b1;
            F_SRAI:  ctrl.alu_op[ALU_SRA] = 1'b1;
            default: known = 1'b0;
          endcase
        end else if (inst.r3.op4 == MN_3R && inst.r3.op2 == F2_TRAP) begin
          ctrl.rf_we = 1'b0;
          case (inst.r3.op5)
            F_SYSCALL: ctrl.exc.sys = 1'b1;
            F_BREAK:   ctrl.exc.brk = 1'b1;
            default:   known = 1'b0;
          endcase
        end else begin
          // 2RI12 arithmetic with immediate
          ctrl.src2_is_imm = 1'b1;
          case (inst.ri12.op4)
            MN_SLTI:  ctrl.alu_op[ALU_SLT]  = 1'b1;
            MN_SLTUI: ctrl.alu_op[ALU_SLTU] = 1'b1;
            MN_ADDI:  ctrl.alu_op[ALU_ADD]  = 1'b1;
            MN_ANDI:  ctrl.alu_op[ALU_AND]  = 1'b1;
            MN_ORI:   ctrl.alu_op[ALU_OR]   = 1'b1;
            MN_XORI:  ctrl.alu_op[ALU_XOR]  = 1'b1;
            default:  known = 1'b0;
          endcase
        end
      end
      OP_LU12I: begin
        ctrl.alu_op[ALU_LUI] = 1'b1;
        ctrl.src2_is_imm     = 1'b1;
        known                = !inst.ri20.op1;
      end
      OP_PCADDU: begin
        ctrl.alu_op[ALU_ADD] = 1'b1;
        ctrl.src1_is_pc      = 1'b1;
        ctrl.src2_is_imm     = 1'b1;
        known                = !inst.ri20.op1;
      end
      OP_MEM: begin
        // Address is rj + si12
        ctrl.alu_op[ALU_ADD] = 1'b1;
        ctrl.src2_is_imm     = 1'b1;
        case (inst.ri12.op4)
          MN_LD_B:  ctrl.ld_ctrl.b  = 1'b1;
          MN_LD_H:  ctrl.ld_ctrl.h  = 1'b1;
          MN_LD_W:  ctrl.ld_ctrl.w  = 1'b1;
          MN_LD_BU: ctrl.ld_ctrl.bu = 1'b1;
          MN_LD_HU: ctrl.ld_ctrl.hu = 1'b1;
          MN_ST_B:  ctrl.st_ctrl.b  = 1'b1;
          MN_ST_H:  ctrl.st_ctrl.h  = 1'b1;
          MN_ST_W:  ctrl.st_ctrl.w  = 1'b1;
          default:  known = 1'b0;
        endcase
      end
      OP_JIRL, OP_BL: begin
        // Link value pc + 4 goes through the ALU
        ctrl.br_kind         = (inst.r3.op6 == OP_BL) ? BR_BL : BR_JIRL;
        ctrl.alu_op[ALU_ADD] = 1'b1;
        ctrl.src1_is_pc      = 1'b1;
        ctrl.src2_is_imm     = 1'b1;
        if (inst.r3.op6 == OP_BL) begin
          ctrl.dest = 5'd1;
        end
      end
      OP_B: begin
        ctrl.br_kind = BR_B;
        ctrl.rf_we   = 1'b0;
      end
      OP_BEQ:  ctrl.br_kind = BR_BEQ;
      OP_BNE:  ctrl.br_kind = BR_BNE;
      OP_BLT:  ctrl.br_kind = BR_BLT;
      OP_BGE:  ctrl.br_kind = BR_BGE;
      OP_BLTU: ctrl.br_kind = BR_BLTU;
      OP_BGEU: ctrl.br_kind = BR_BGEU;
      default: known = 1'b0;
    endcase

    // Stores and compares read rd on the second port
    if ((|ctrl.st_ctrl) ||
        ctrl.br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU}) begin
      ctrl.src_reg_is_rd = 1'b1;
      ctrl.rf_we         = 1'b0;
    end

    if (!known) begin
      ctrl         = '0;
      ctrl.dest    = inst.r3.rd;
      ctrl.exc.ine = 1'b1;
    end
  end

endmodule

//--- id_imm_gen.sv
`timescale 1ns/1ps

module id_imm_gen (
  input  id_pkg::inst_word_u inst,
  input  id_pkg::dec_ctrl_t  ctrl,
  output logic [31:0]        imm,
  output logic [31:0]        br_offs
);
  import id_pkg::*;

  logic is_link;
  logic is_shift;
  logic is_logic;
  logic is_upper;
  logic is_far;

  assign is_link  = ctrl.br_kind inside {BR_BL, BR_JIRL};
  assign is_shift = ctrl.src2_is_imm && (|ctrl.alu_op[ALU_SRA:ALU_SLL]);
  assign is_logic = ctrl.src2_is_imm &&
                    (ctrl.alu_op[ALU_AND] || ctrl.alu_op[ALU_OR] || ctrl.alu_op[ALU_XOR]);
  // lu12i.w and pcaddu12i
  assign is_upper = ctrl.alu_op[ALU_LUI] || (ctrl.src1_is_pc && !is_link);
  assign is_far   = ctrl.br_kind inside {BR_B, BR_BL};

  always_comb begin
    if (is_link) begin
      imm = 32'd4;
    end else if (is_upper) begin
      imm = {inst.ri20.i20, 12'b0};
    end else if (is_shift) begin
      imm = {27'b0, inst.r3.rk};
    end else if (is_logic) begin
      imm = {20'b0, inst.ri12.i12};
    end else begin
      imm = {{20{inst.ri12.i12[11]}}, inst.ri12.i12};
    end
  end

  assign br_offs = is_far ?
                   {{4{inst.i26.offs_hi[9]}}, inst.i26.offs_hi, inst.i26.offs_lo, 2'b0} :
                   {{14{inst.ri16.i16[15]}}, inst.ri16.i16, 2'b0};

endmodule

//--- id_decode_stage.sv
`timescale 1ns/1ps

module id_decode_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               inst_valid,
  input  id_pkg::inst_word_u inst,
  input  logic [31:0]        pc,
  output logic               id_allow_in,
  input  logic               s1_allow,
  input  logic               kill,
  output logic               s1_valid,
  output id_pkg::id_s1_t     s1
);
  import id_pkg::*;

  dec_ctrl_t   dec;
  logic [31:0] imm;
  logic [31:0] br_offs;
  logic        load;

  id_inst_decoder u_dec (
    .inst (inst),
    .ctrl (dec)
  );

  id_imm_gen u_imm (
    .inst    (inst),
    .ctrl    (dec),
    .imm     (imm),
    .br_offs (br_offs)
  );

  assign id_allow_in = !s1_valid || s1_allow;
  assign load        = inst_valid && id_allow_in;

  // Wrong-path word is dropped on the edge its branch leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (id_allow_in) begin
      s1_valid <= inst_valid && !kill;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      s1.pc      <= pc;
      s1.rj      <= inst.r3.rj;
      s1.rd      <= inst.r3.rd;
      s1.rk      <= inst.r3.rk;
      s1.ctrl    <= dec;
      s1.imm     <= imm;
      s1.br_offs <= br_offs;
    end
  end

  a_dec_one_class: assert property (@(posedge clk) disable iff (rst)
    inst_valid |-> $onehot0(dec.alu_op) &&
                   !(dec.br_kind != BR_NONE && ((|dec.ld_ctrl) || (|dec.st_ctrl))));

endmodule

//--- id_regfile.sv
`timescale 1ns/1ps

module id_regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        wb_we,
  input  logic [4:0]  wb_addr,
  input  logic [31:0] wb_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_addr != 5'd0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // No bypass, a write shows up the next cycle
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  a_r0_zero: assert property (@(posedge clk) disable iff (rst)
    (raddr1 == 5'd0 -> rdata1 == '0) && (raddr2 == 5'd0 -> rdata2 == '0));

endmodule

//--- id_operand_stage.sv
`timescale 1ns/1ps

module id_operand_stage (
  input  logic           clk,
  input  logic           rst,
  input  logic           s1_valid,
  input  id_pkg::id_s1_t s1,
  output logic           s1_allow,
  output logic [4:0]     raddr1,
  output logic [4:0]     raddr2,
  input  logic [31:0]    rdata1,
  input  logic [31:0]    rdata2,
  output logic           kill,
  input  logic           ex_allow_in,
  output logic           ex_valid,
  output id_pkg::id_ex_t ex_bus,
  output id_pkg::br_t    br
);
  import id_pkg::*;

  logic        load;
  logic        eq;
  logic        lt_s;
  logic        lt_u;
  logic        taken;
  logic [31:0] target;
  id_ex_t      nxt;

  assign s1_allow = !ex_valid || ex_allow_in;
  assign load     = s1_valid && s1_allow;

  assign raddr1 = s1.rj;
  assign raddr2 = s1.ctrl.src_reg_is_rd ? s1.rd : s1.rk;

  // rj against rkd
  assign eq   = rdata1 == rdata2;
  assign lt_s = $signed(rdata1) < $signed(rdata2);
  assign lt_u = rdata1 < rdata2;

  always_comb begin
    case (s1.ctrl.br_kind)
      BR_B, BR_BL, BR_JIRL: taken = 1'b1;
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = !eq;
      BR_BLT:  taken = lt_s;
      BR_BGE:  taken = !lt_s;
      BR_BLTU: taken = lt_u;
      BR_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  assign target = (s1.ctrl.br_kind == BR_JIRL ? rdata1 : s1.pc) + s1.br_offs;
  assign kill   = load && taken;

  always_comb begin
    nxt.alu_op   = s1.ctrl.alu_op;
    nxt.alu_src1 = s1.ctrl.src1_is_pc ? s1.pc : rdata1;
    nxt.alu_src2 = s1.ctrl.src2_is_imm ? s1.imm : rdata2;
    nxt.st_data  = rdata2;
    nxt.ld_ctrl  = s1.ctrl.ld_ctrl;
    nxt.st_ctrl  = s1.ctrl.st_ctrl;
    nxt.mem_en   = (|s1.ctrl.ld_ctrl) || (|s1.ctrl.st_ctrl);
    nxt.rf_we    = s1.ctrl.rf_we;
    nxt.dest     = s1.ctrl.dest;
    nxt.pc       = s1.pc;
    nxt.exc      = s1.ctrl.exc;
  end

  always_ff @(posedge clk) begin
    if (load) begin
      ex_bus    <= nxt;
      br.target <= target;
    end
    if (rst) begin
      ex_valid <= 1'b0;
      br.taken <= 1'b0;
    end else if (s1_allow) begin
      ex_valid <= s1_valid;
      br.taken <= s1_valid && taken;
    end
  end

  a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
    ex_valid && !ex_allow_in |=> $stable(ex_bus) && $stable(br));

endmodule

//--- id_pipe.sv
`timescale 1ns/1ps

module id_pipe (
  input  logic               clk,
  input  logic               rst,
  input  logic               inst_valid,
  input  id_pkg::inst_word_u inst,
  input  logic [31:0]        pc,
  output logic               id_allow_in,
  input  logic               wb_we,
  input  logic [4:0]         wb_addr,
  input  logic [31:0]        wb_data,
  input  logic               ex_allow_in,
  output logic               ex_valid,
  output id_pkg::id_ex_t     ex_bus,
  output id_pkg::br_t        br
);
  import id_pkg::*;

  logic        s1_valid;
  logic        s1_allow;
  logic        kill;
  id_s1_t      s1;
  logic [4:0]  raddr1;
  logic [4:0]  raddr2;
  logic [31:0] rdata1;
  logic [31:0] rdata2;

  id_decode_stage u_decode (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .pc          (pc),
    .id_allow_in (id_allow_in),
    .s1_allow    (s1_allow),
    .kill        (kill),
    .s1_valid    (s1_valid),
    .s1          (s1)
  );

  id_operand_stage u_operand (
    .clk         (clk),
    .rst         (rst),
    .s1_valid    (s1_valid),
    .s1          (s1),
    .s1_allow    (s1_allow),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .kill        (kill),
    .ex_allow_in (ex_allow_in),
    .ex_valid    (ex_valid),
    .ex_bus      (ex_bus),
    .br          (br)
  );

  id_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .raddr1  (raddr1),
    .raddr2  (raddr2),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .wb_we   (wb_we),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

endmodule

//--- tb_id_pipe.sv
`timescale 1ns/1ps

module tb_id_pipe;
  import id_pkg::*;

  typedef enum int {
    M_ADD, M_SUB, M_SLT, M_SLTU, M_NOR, M_AND, M_OR, M_XOR, M_SLL, M_SRL, M_SRA,
    M_SLLI, M_SRLI, M_SRAI, M_SLTI, M_SLTUI, M_ADDI, M_ANDI, M_ORI, M_XORI,
    M_LU12I, M_PCADDU12I, M_LDB, M_LDH, M_LDW, M_LDBU, M_LDHU, M_STB, M_STH, M_STW,
    M_JIRL, M_B, M_BL, M_BEQ, M_BNE, M_BLT, M_BGE, M_BLTU, M_BGEU,
    M_SYSCALL, M_BREAK, M_BAD
  } mnem_t;

  localparam int WAIT_LIMIT = 50;

  logic        clk;
  logic        rst;
  logic        inst_valid;
  inst_word_u  inst;
  logic [31:0] pc;
  logic        id_allow_in;
  logic        wb_we;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic        ex_allow_in;
  logic        ex_valid;
  id_ex_t      ex_bus;
  br_t         br;

  // Register values as written through write-back
  logic [31:0] regs_m [32];
  logic [31:0] cur_pc;

  id_pipe i_id_pipe (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .pc          (pc),
    .id_allow_in (id_allow_in),
    .wb_we       (wb_we),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .ex_allow_in (ex_allow_in),
    .ex_valid    (ex_valid),
    .ex_bus      (ex_bus),
    .br          (br)
  );

  always #5 clk = ~clk;

  task automatic end_with_failure();
    $display("Checks failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check(string name, logic [191:0] exp, logic [191:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      end_with_failure();
    end
  endtask

  // LA32 encodings
  function automatic logic [31:0] encode(mnem_t mn, logic [4:0] rd, logic [4:0] rj,
                                         logic [4:0] rk, int imm);
    logic [31:0] w;
    logic [25:0] o26;
    o26 = imm[25:0];
    case (mn)
      M_ADD:       w = {17'h00020, rk, rj, rd};
      M_SUB:       w = {17'h00022, rk, rj, rd};
      M_SLT:       w = {17'h00024, rk, rj, rd};
      M_SLTU:      w = {17'h00025, rk, rj, rd};
      M_NOR:       w = {17'h00028, rk, rj, rd};
      M_AND:       w = {17'h00029, rk, rj, rd};
      M_OR:        w = {17'h0002a, rk, rj, rd};
      M_XOR:       w = {17'h0002b, rk, rj, rd};
      M_SLL:       w = {17'h0002e, rk, rj, rd};
      M_SRL:       w = {17'h0002f, rk, rj, rd};
      M_SRA:       w = {17'h00030, rk, rj, rd};
      M_SLLI:      w = {17'h00081, imm[4:0], rj, rd};
      M_SRLI:      w = {17'h00089, imm[4:0], rj, rd};
      M_SRAI:      w = {17'h00091, imm[4:0], rj, rd};
      M_SLTI:      w = {10'h008, imm[11:0], rj, rd};
      M_SLTUI:     w = {10'h009, imm[11:0], rj, rd};
      M_ADDI:      w = {10'h00a, imm[11:0], rj, rd};
      M_ANDI:      w = {10'h00d, imm[11:0], rj, rd};
      M_ORI:       w = {10'h00e, imm[11:0], rj, rd};
      M_XORI:      w = {10'h00f, imm[11:0], rj, rd};
      M_LU12I:     w = {7'h0a, imm[19:0], rd};
      M_PCADDU12I: w = {7'h0e, imm[19:0], rd};
      M_LDB:       w = {10'h0a0, imm[11:0], rj, rd};
      M_LDH:       w = {10'h0a1, imm[11:0], rj, rd};
      M_LDW:       w = {10'h0a2, imm[11:0], rj, rd};
      M_STB:       w = {10'h0a4, imm[11:0], rj, rd};
      M_STH:       w = {10'h0a5, imm[11:0], rj, rd};
      M_STW:       w = {10'h0a6, imm[11:0], rj, rd};
      M_LDBU:      w = {10'h0a8, imm[11:0], rj, rd};
      M_LDHU:      w = {10'h0a9, imm[11:0], rj, rd};
      M_JIRL:      w = {6'h13, imm[15:0], rj, rd};
      M_B:         w = {6'h14, o26[15:0], o26[25:16]};
      M_BL:        w = {6'h15, o26[15:0], o26[25:16]};
      M_BEQ:       w = {6'h16, imm[15:0], rj, rd};
      M_BNE:       w = {6'h17, imm[15:0], rj, rd};
      M_BLT:       w = {6'h18, imm[15:0], rj, rd};
      M_BGE:       w = {6'h19, imm[15:0], rj, rd};
      M_BLTU:      w = {6'h1a, imm[15:0], rj, rd};
      M_BGEU:      w = {6'h1b, imm[15:0], rj, rd};
      M_SYSCALL:   w = {17'h00056, imm[14:0]};
      M_BREAK:     w = {17'h00054, imm[14:0]};
      default:     w = imm;
    endcase
    return w;
  endfunction

  function automatic alu_op_t alu_bit(int pos);
    return alu_op_t'(1) << pos;
  endfunction

  function automatic id_ex_t model_ex(mnem_t mn, logic [31:0] w, logic [31:0] pcv, int imm);
    id_ex_t e;
    logic   rd_port;
    rd_port = mn inside {M_STB, M_STH, M_STW, M_BEQ, M_BNE, M_BLT, M_BGE, M_BLTU, M_BGEU};
    e          = '0;
    e.alu_src1 = regs_m[w[9:5]];
    e.alu_src2 = regs_m[rd_port ? w[4:0] : w[14:10]];
    e.st_data  = e.alu_src2;
    e.dest     = w[4:0];
    e.pc       = pcv;
    e.rf_we    = !(rd_port || mn inside {M_B, M_SYSCALL, M_BREAK, M_BAD});
    if (mn inside {M_SLLI, M_SRLI, M_SRAI}) begin
      e.alu_src2 = {27'b0, imm[4:0]};
    end else if (mn inside {M_ANDI, M_ORI, M_XORI}) begin
      e.alu_src2 = imm & 32'hfff;
    end else if (mn inside {M_LU12I, M_PCADDU12I}) begin
      e.alu_src2 = imm << 12;
    end else if (mn inside {M_JIRL, M_BL}) begin
      e.alu_src2 = 32'd4;
    end else if (mn inside {M_SLTI, M_SLTUI, M_ADDI, M_LDB, M_LDH, M_LDW, M_LDBU, M_LDHU,
                            M_STB, M_STH, M_STW}) begin
      e.alu_src2 = imm;
    end
    if (mn inside {M_PCADDU12I, M_JIRL, M_BL}) begin
      e.alu_src1 = pcv;
    end
    if (mn == M_BL) begin
      e.dest = 5'd1;
    end
    case (mn)
      M_ADD, M_ADDI, M_PCADDU12I, M_JIRL, M_BL: e.alu_op = alu_bit(ALU_ADD);
      M_SUB:                e.alu_op = alu_bit(ALU_SUB);
      M_SLT, M_SLTI:        e.alu_op = alu_bit(ALU_SLT);
      M_SLTU, M_SLTUI:      e.alu_op = alu_bit(ALU_SLTU);
      M_NOR:                e.alu_op = alu_bit(ALU_NOR);
      M_AND, M_ANDI:        e.alu_op = alu_bit(ALU_AND);
      M_OR, M_ORI:          e.alu_op = alu_bit(ALU_OR);
      M_XOR, M_XORI:        e.alu_op = alu_bit(ALU_XOR);
      M_SLL, M_SLLI:        e.alu_op = alu_bit(ALU_SLL);
      M_SRL, M_SRLI:        e.alu_op = alu_bit(ALU_SRL);
      M_SRA, M_SRAI:        e.alu_op = alu_bit(ALU_SRA);
      M_LU12I:              e.alu_op = alu_bit(ALU_LUI);
      M_SYSCALL:            e.exc.sys = 1'b1;
      M_BREAK:              e.exc.brk = 1'b1;
      M_BAD:                e.exc.ine = 1'b1;
      default: ;
    endcase
    // Address add for every memory access
    if (mn inside {M_LDB, M_LDH, M_LDW, M_LDBU, M_LDHU, M_STB, M_STH, M_STW}) begin
      e.alu_op = alu_bit(ALU_ADD);
      e.mem_en = 1'b1;
    end
    e.ld_ctrl.b  = mn == M_LDB;
    e.ld_ctrl.h  = mn == M_LDH;
    e.ld_ctrl.w  = mn == M_LDW;
    e.ld_ctrl.bu = mn == M_LDBU;
    e.ld_ctrl.hu = mn == M_LDHU;
    e.st_ctrl.b  = mn == M_STB;
    e.st_ctrl.h  = mn == M_STH;
    e.st_ctrl.w  = mn == M_STW;
    return e;
  endfunction

  function automatic br_t model_br(mnem_t mn, logic [31:0] w, logic [31:0] pcv, int imm);
    br_t         b;
    logic [31:0] vj;
    logic [31:0] vd;
    vj       = regs_m[w[9:5]];
    vd       = regs_m[w[4:0]];
    b.target = pcv + (imm << 2);
    case (mn)
      M_B, M_BL: b.taken = 1'b1;
      M_JIRL: begin
        b.taken  = 1'b1;
        b.target = vj + (imm << 2);
      end
      M_BEQ:   b.taken = vj == vd;
      M_BNE:   b.taken = vj != vd;
      M_BLT:   b.taken = $signed(vj) < $signed(vd);
      M_BGE:   b.taken = $signed(vj) >= $signed(vd);
      M_BLTU:  b.taken = vj < vd;
      M_BGEU:  b.taken = vj >= vd;
      default: b.taken = 1'b0;
    endcase
    return b;
  endfunction

  task automatic write_reg(logic [4:0] addr, logic [31:0] data);
    wb_we   = 1'b1;
    wb_addr = addr;
    wb_data = data;
    @(negedge clk);
    wb_we = 1'b0;
    if (addr != 5'd0) begin
      regs_m[addr] = data;
    end
  endtask

  // Holds the word until the decode stage takes it
  task automatic send(logic [31:0] w, logic [31:0] pcv);
    int cnt;
    cnt        = 0;
    inst_valid = 1'b1;
    inst       = w;
    pc         = pcv;
    #1;
    while (!id_allow_in) begin
      @(negedge clk);
      #1;
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("Timeout: decode stage never accepted the instruction at pc %h", pcv);
        end_with_failure();
      end
    end
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic expect_out(string name, id_ex_t e, br_t b);
    int cnt;
    cnt = 0;
    while (!ex_valid) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("Timeout: output never became valid in %s", name);
        end_with_failure();
      end
    end
    check(name, e, ex_bus);
    check({name, " br.taken"}, b.taken, br.taken);
    if (b.taken) begin
      check({name, " br.target"}, b.target, br.target);
    end
    @(negedge clk);
  endtask

  task automatic run_one(string name, mnem_t mn, logic [4:0] rd, logic [4:0] rj,
                         logic [4:0] rk, int imm);
    logic [31:0] w;
    id_ex_t      e;
    br_t         b;
    w = encode(mn, rd, rj, rk, imm);
    e = model_ex(mn, w, cur_pc, imm);
    b = model_br(mn, w, cur_pc, imm);
    send(w, cur_pc);
    expect_out(name, e, b);
    cur_pc += 4;
  endtask

  // Branch with an addi right behind it
  task automatic run_branch(string name, mnem_t mn, logic [4:0] rd, logic [4:0] rj, int offs);
    logic [31:0] w;
    logic [31:0] fw;
    id_ex_t      e;
    id_ex_t      fe;
    br_t         b;
    br_t         fb;
    w  = encode(mn, rd, rj, 5'd0, offs);
    fw = encode(M_ADDI, 5'd2, 5'd0, 5'd0, 1);
    e  = model_ex(mn, w, cur_pc, offs);
    b  = model_br(mn, w, cur_pc, offs);
    fe = model_ex(M_ADDI, fw, cur_pc + 4, 1);
    fb = model_br(M_ADDI, fw, cur_pc + 4, 1);
    send(w, cur_pc);
    send(fw, cur_pc + 4);
    expect_out(name, e, b);
    if (b.taken) begin
      for (int i = 0; i < 4; i++) begin
        check({name, " wrong-path killed"}, 1'b0, ex_valid);
        @(negedge clk);
      end
    end else begin
      expect_out({name, " follower"}, fe, fb);
    end
    cur_pc += 8;
  endtask

  task automatic test_reset();
    check("reset ex_valid", 1'b0, ex_valid);
    check("reset br.taken", 1'b0, br.taken);
    check("reset id_allow_in", 1'b1, id_allow_in);
  endtask

  task automatic test_alu();
    mnem_t r3_ops [11] = '{M_ADD, M_SUB, M_SLT, M_SLTU, M_NOR, M_AND, M_OR, M_XOR,
                           M_SLL, M_SRL, M_SRA};
    for (int i = 1; i < 16; i++) begin
      write_reg(5'(i), $urandom);
    end
    // Must not land in r0
    write_reg(5'd0, 32'hdead_beef);
    foreach (r3_ops[i]) begin
      run_one(r3_ops[i].name(), r3_ops[i], 5'd3, 5'd4, 5'd5, 0);
    end
    run_one("add.w from r0", M_ADD, 5'd3, 5'd0, 5'd5, 0);
    run_one("slli.w", M_SLLI, 5'd6, 5'd4, 5'd0, 7);
    run_one("srli.w", M_SRLI, 5'd6, 5'd7, 5'd0, 31);
    run_one("srai.w", M_SRAI, 5'd6, 5'd8, 5'd0, 13);
    run_one("slti", M_SLTI, 5'd9, 5'd4, 5'd0, -5);
    run_one("sltui", M_SLTUI, 5'd9, 5'd4, 5'd0, -1);
    run_one("addi.w", M_ADDI, 5'd10, 5'd11, 5'd0, -100);
    run_one("andi", M_ANDI, 5'd10, 5'd12, 5'd0, 'hf0f);
    run_one("ori", M_ORI, 5'd10, 5'd13, 5'd0, 'h800);
    run_one("xori", M_XORI, 5'd10, 5'd14, 5'd0, 'hfff);
    run_one("lu12i.w", M_LU12I, 5'd15, 5'd0, 5'd0, 'h80001);
    run_one("pcaddu12i", M_PCADDU12I, 5'd15, 5'd0, 5'd0, 'h12345);
  endtask

  task automatic test_mem();
    write_reg(5'd8, 32'h1000_0000);
    write_reg(5'd9, $urandom);
    run_one("ld.b", M_LDB, 5'd7, 5'd8, 5'd0, -4);
    run_one("ld.h", M_LDH, 5'd7, 5'd8, 5'd0, 2046);
    run_one("ld.w", M_LDW, 5'd7, 5'd8, 5'd0, -2048);
    run_one("ld.bu", M_LDBU, 5'd7, 5'd8, 5'd0, 1);
    run_one("ld.hu", M_LDHU, 5'd7, 5'd8, 5'd0, 'h7ff);
    run_one("st.b", M_STB, 5'd9, 5'd8, 5'd0, -1);
    run_one("st.h", M_STH, 5'd9, 5'd8, 5'd0, 100);
    run_one("st.w", M_STW, 5'd9, 5'd8, 5'd0, -2048);
  endtask

  task automatic test_branch();
    write_reg(5'd20, 32'd5);
    write_reg(5'd21, 32'd5);
    write_reg(5'd22, 32'hffff_fffd);
    write_reg(5'd23, 32'd7);
    run_branch("beq taken", M_BEQ, 5'd21, 5'd20, 16);
    run_branch("beq not taken", M_BEQ, 5'd23, 5'd20, 16);
    run_branch("bne taken", M_BNE, 5'd23, 5'd20, -12);
    run_branch("bne not taken", M_BNE, 5'd21, 5'd20, -12);
    run_branch("blt taken", M_BLT, 5'd20, 5'd22, 40);
    run_branch("blt not taken", M_BLT, 5'd22, 5'd20, 40);
    run_branch("bge taken", M_BGE, 5'd22, 5'd20, -3);
    run_branch("bge not taken", M_BGE, 5'd20, 5'd22, -3);
    run_branch("bltu taken", M_BLTU, 5'd22, 5'd20, 9);
    run_branch("bltu not taken", M_BLTU, 5'd20, 5'd22, 9);
    run_branch("bgeu taken", M_BGEU, 5'd20, 5'd22, 2);
    run_branch("bgeu not taken", M_BGEU, 5'd22, 5'd20, 2);
    run_branch("b", M_B, 5'd0, 5'd0, -300);
    run_branch("bl", M_BL, 5'd0, 5'd0, 'h12345);
    run_branch("jirl", M_JIRL, 5'd1, 5'd20, -8);
  endtask

  task automatic test_exc();
    run_one("syscall", M_SYSCALL, 5'd0, 5'd0, 5'd0, 'h15);
    run_one("break", M_BREAK, 5'd0, 5'd0, 5'd0, 3);
    run_one("undefined word", M_BAD, 5'd0, 5'd0, 5'd0, 32'hfc00_0000);
    run_one("all-zero word", M_BAD, 5'd0, 5'd0, 5'd0, 0);
  endtask

  task automatic test_backpressure();
    logic [31:0] words [10];
    id_ex_t      exps [10];
    id_ex_t      held_bus;
    br_t         held_br;
    logic        held_v;
    int          sent;
    int          got;
    int          cycles;
    for (int i = 0; i < 10; i++) begin
      words[i] = encode(M_ADDI, 5'(i + 2), 5'd4, 5'd0, i * 3 - 7);
      exps[i]  = model_ex(M_ADDI, words[i], cur_pc + 4 * i, i * 3 - 7);
    end
    sent   = 0;
    got    = 0;
    cycles = 0;
    held_v = 1'b0;
    while (got < 10) begin
      if (held_v) begin
        check("stall ex_valid", 1'b1, ex_valid);
        check("stall ex_bus hold", held_bus, ex_bus);
        check("stall br hold", held_br, br);
      end
      ex_allow_in = 1'($urandom_range(0, 1));
      held_v      = ex_valid && !ex_allow_in;
      held_bus    = ex_bus;
      held_br     = br;
      if (ex_valid && ex_allow_in) begin
        check($sformatf("stream item %0d", got), exps[got], ex_bus);
        got++;
      end
      if (sent < 10) begin
        inst_valid = 1'b1;
        inst       = words[sent];
        pc         = cur_pc + 4 * sent;
      end else begin
        inst_valid = 1'b0;
      end
      #1;
      if (inst_valid && id_allow_in) begin
        sent++;
      end
      @(negedge clk);
      cycles++;
      if (cycles > 200) begin
        $display("Timeout: stream output never completed, %0d of 10 received", got);
        end_with_failure();
      end
    end
    inst_valid  = 1'b0;
    ex_allow_in = 1'b1;
    cur_pc += 40;
    @(negedge clk);
    check("stream no extra output", 1'b0, ex_valid);
  endtask

  initial begin
    void'($urandom(92106));
    clk         = 1'b0;
    rst         = 1'b1;
    inst_valid  = 1'b0;
    inst        = '0;
    pc          = '0;
    wb_we       = 1'b0;
    wb_addr     = '0;
    wb_data     = '0;
    ex_allow_in = 1'b1;
    cur_pc      = 32'h1c00_0000;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_alu();
    test_mem();
    test_branch();
    test_exc();
    test_backpressure();
    $display("All checks passed");
    $finish;
  end

endmodule

//--- id_pipe.f
id_pkg.sv
id_inst_decoder.sv
id_imm_gen.sv
id_decode_stage.sv
id_regfile.sv
id_operand_stage.sv
id_pipe.sv
tb_id_pipe.sv

//--- Bender.yml
package:
  name: id_pipe

sources:
  - id_pkg.sv
  - id_inst_decoder.sv
  - id_imm_gen.sv
  - id_decode_stage.sv
  - id_regfile.sv
  - id_operand_stage.sv
  - id_pipe.sv
  - target: test
    files:
      - tb_id_pipe.sv
